// File: wb_sdram_ctrl_top.f
+incdir+verilog
verilog/sdram_ctrl_pkg.sv
verilog/wb_cmd_packer.sv
verilog/cmd_fifo.sv
verilog/sdr_cmd_seq.sv
verilog/wb_sdram_ctrl_top.sv
testbench/sdram_ctrl_chk.sv
testbench/tb_wb_sdram_ctrl.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_wb_sdram_ctrl -f wb_sdram_ctrl_top.f \
   || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_wb_sdram_ctrl 2>&1)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: testbench/tb_wb_sdram_ctrl.sv
`default_nettype none

`include "sdram_ctrl_defs.svh"

module tb_wb_sdram_ctrl;

   localparam int CLK_PERIOD  = 20;
   localparam int ACK_TIMEOUT = 200;

   typedef struct {
      string                    name;
      logic                     we;
      sdram_ctrl_pkg::wb_adr_t  adr;
      sdram_ctrl_pkg::wb_sel_t  sel;
      sdram_ctrl_pkg::wb_data_t dat;
      sdram_ctrl_pkg::wb_data_t exp;
      logic                     burst;
   } step_t;

   logic                       sdram_clk_0;
   logic                       wb_rst;
   logic [`WB_ADR_W-1:0]       wb_adr_i;
   logic [`WB_DAT_W-1:0]       wb_dat_i;
   logic [`WB_SEL_W-1:0]       wb_sel_i;
   logic                       wb_we_i;
   logic                       wb_cyc_i;
   logic                       wb_stb_i;
   logic [`SDR_DQ_W-1:0]       dq_i = '0;
   wire  [`WB_DAT_W-1:0]       wb_dat_o;
   wire                        wb_ack_o;
   wire                        ras_n_o;
   wire                        cas_n_o;
   wire                        we_n_o;
   wire  [`SDR_BA_W-1:0]       ba_o;
   wire  [`SDR_A_W-1:0]        a_o;
   wire  [`SDR_DQM_W-1:0]      dqm_o;
   wire  [`SDR_DQ_W-1:0]       dq_o;
   wire                        dq_oe_o;
   sdram_ctrl_pkg::sdr_cmd_e   bus_cmd;

   step_t                      steps [$];
   sdram_ctrl_pkg::wb_data_t   ref_mem [sdram_ctrl_pkg::wb_adr_t];
   logic [`SDR_DQ_W-1:0]       sdram_mem [bit [24:0]];
   logic [`SDR_A_W-1:0]        row_q [4];
   logic [31:0]                rng_state = 32'h3a4343c6;
   int                         cycle_cnt = 0;
   int                         ref_count = 0;
   int                         nop_left = 0;
   int                         rd_age = -1;
   bit                         wr_lo_pend = 1'b0;
   bit [24:0]                  wr_key;
   bit [24:0]                  rd_key;

   assign bus_cmd = sdram_ctrl_pkg::sdr_cmd_e'({ras_n_o, cas_n_o, we_n_o});

   wb_sdram_ctrl_top i_wb_sdram_ctrl_top (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .dq_i        (dq_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .ras_n_o     (ras_n_o),
      .cas_n_o     (cas_n_o),
      .we_n_o      (we_n_o),
      .ba_o        (ba_o),
      .a_o         (a_o),
      .dqm_o       (dqm_o),
      .dq_o        (dq_o),
      .dq_oe_o     (dq_oe_o)
   );

   initial begin
      sdram_clk_0 = 1'b0;
      forever #(CLK_PERIOD / 2) sdram_clk_0 = ~sdram_clk_0;
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic check_data(string name, sdram_ctrl_pkg::wb_data_t exp,
                             sdram_ctrl_pkg::wb_data_t act);
      if (act !== exp) begin
         abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_cmd(string name, sdram_ctrl_pkg::sdr_cmd_e exp,
                            sdram_ctrl_pkg::sdr_cmd_e act);
      if (act !== exp) begin
         abort_run($sformatf("ERROR %s: expected %s, actual %s", name, exp.name(), act.name()));
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // lower bound on an event count
   task automatic check_count(string name, int min_exp, int act);
      if (act < min_exp) begin
         abort_run($sformatf("ERROR %s: expected at least %0d, actual %0d", name, min_exp, act));
      end
   endtask

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // byte lanes with sel high take the new word
   function automatic sdram_ctrl_pkg::wb_data_t merge_bytes(sdram_ctrl_pkg::wb_data_t old_w,
                                                            sdram_ctrl_pkg::wb_data_t new_w,
                                                            sdram_ctrl_pkg::wb_sel_t sel);
      sdram_ctrl_pkg::wb_data_t res;
      res = old_w;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            res[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return res;
   endfunction

   function automatic void add_write(string name, sdram_ctrl_pkg::wb_adr_t adr,
                                     sdram_ctrl_pkg::wb_sel_t sel,
                                     sdram_ctrl_pkg::wb_data_t dat, logic burst);
      step_t s;
      sdram_ctrl_pkg::wb_data_t old_w;
      old_w = ref_mem.exists(adr) ? ref_mem[adr] : '0;
      ref_mem[adr] = merge_bytes(old_w, dat, sel);
      s.name  = name;
      s.we    = 1'b1;
      s.adr   = adr;
      s.sel   = sel;
      s.dat   = dat;
      s.exp   = ref_mem[adr];
      s.burst = burst;
      steps.push_back(s);
   endfunction

   function automatic void add_read(string name, sdram_ctrl_pkg::wb_adr_t adr);
      step_t s;
      s.name  = name;
      s.we    = 1'b0;
      s.adr   = adr;
      s.sel   = 4'hf;
      s.dat   = '0;
      s.exp   = ref_mem.exists(adr) ? ref_mem[adr] : '0;
      s.burst = 1'b0;
      steps.push_back(s);
   endfunction

   task automatic build_table();
      logic [31:0]             r;
      sdram_ctrl_pkg::wb_adr_t a;
      sdram_ctrl_pkg::wb_adr_t spread [5];
      r = next_rand();
      a = r[22:0];
      add_write("full_wr", a, 4'hf, next_rand(), 1'b0);
      add_read("full_rd", a);
      add_write("partial_wr", a, 4'b1001, next_rand(), 1'b0);
      add_read("partial_rd", a);
      // one row per bank, plus a second row in bank 0 at the same column
      for (int b = 0; b < 4; b++) begin
         r = next_rand();
         spread[b] = {2'(b), r[20:0]};
      end
      spread[4] = {2'd0, ~spread[0][20:8], spread[0][7:0]};
      for (int b = 0; b < 5; b++) begin
         add_write($sformatf("spread_wr_%0d", b), spread[b], 4'hf, next_rand(), 1'b0);
      end
      for (int b = 0; b < 5; b++) begin
         add_read($sformatf("spread_rd_%0d", b), spread[b]);
      end
      r = next_rand();
      a = r[22:0] & ~23'h7;
      for (int k = 0; k < 6; k++) begin
         add_write($sformatf("burst_wr_%0d", k), a + 23'(k), 4'hf, next_rand(), 1'b1);
      end
      for (int k = 0; k < 6; k++) begin
         add_read($sformatf("burst_rd_%0d", k), a + 23'(k));
      end
      foreach (ref_mem[k]) begin
         add_read("readback", k);
      end
   endtask

   // called just after a falling edge, returns just after one
   task automatic bus_access(input step_t s, output sdram_ctrl_pkg::wb_data_t rd_word,
                             output int waited);
      wb_adr_i = s.adr;
      wb_dat_i = s.dat;
      wb_sel_i = s.sel;
      wb_we_i  = s.we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      waited   = 0;
      #(CLK_PERIOD / 4);
      while (wb_ack_o !== 1'b1) begin
         if (waited >= ACK_TIMEOUT) begin
            abort_run($sformatf("timeout waiting for ack on %s", s.name));
         end else begin
            @(negedge sdram_clk_0);
            #(CLK_PERIOD / 4);
            waited++;
         end
      end
      rd_word = wb_dat_o;
      @(negedge sdram_clk_0);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   function automatic void store_beat(bit [24:0] key, logic [15:0] beat, logic [1:0] mask);
      logic [15:0] old_b;
      old_b = sdram_mem.exists(key) ? sdram_mem[key] : 16'h0;
      if (!mask[1]) begin
         old_b[15:8] = beat[15:8];
      end
      if (!mask[0]) begin
         old_b[7:0] = beat[7:0];
      end
      sdram_mem[key] = old_b;
   endfunction

   function automatic logic [15:0] read_beat(bit [24:0] key);
      return sdram_mem.exists(key) ? sdram_mem[key] : 16'h0;
   endfunction

   // sdram model sees commands mid-cycle and drives read beats ahead of their sampling edges
   always @(negedge sdram_clk_0) begin
      cycle_cnt++;
      if (nop_left > 0) begin
         check_cmd("refresh_recovery", sdram_ctrl_pkg::NOP, bus_cmd);
         nop_left--;
      end else if (bus_cmd == sdram_ctrl_pkg::REFRESH) begin
         ref_count++;
         nop_left = `SDR_TRFC;
      end
      if (wr_lo_pend) begin
         check_bit("write_lo_dq_oe", 1'b1, dq_oe_o);
         store_beat(wr_key, dq_o, dqm_o);
         wr_lo_pend = 1'b0;
      end
      if (rd_age >= 0) begin
         rd_age++;
      end
      if (bus_cmd == sdram_ctrl_pkg::ACTIVATE) begin
         row_q[ba_o] = a_o;
      end else if (bus_cmd == sdram_ctrl_pkg::WRITE) begin
         check_bit("write_hi_dq_oe", 1'b1, dq_oe_o);
         check_bit("write_auto_precharge", 1'b1, a_o[10]);
         wr_key = {ba_o, row_q[ba_o], a_o[9:0]};
         store_beat(wr_key, dq_o, dqm_o);
         wr_key     = wr_key + 25'd1;
         wr_lo_pend = 1'b1;
      end else if (bus_cmd == sdram_ctrl_pkg::READ) begin
         check_bit("read_auto_precharge", 1'b1, a_o[10]);
         rd_key = {ba_o, row_q[ba_o], a_o[9:0]};
         rd_age = 0;
      end
      if (rd_age == `SDR_CL) begin
         dq_i = read_beat(rd_key);
      end else if (rd_age == `SDR_CL + 1) begin
         dq_i   = read_beat(rd_key + 25'd1);
         rd_age = -1;
      end
   end

   initial begin
      sdram_ctrl_pkg::wb_data_t rd_word;
      int                       waited;
      int                       burst_stalls;
      burst_stalls = 0;
      wb_rst   = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      repeat (5) @(posedge sdram_clk_0);
      @(negedge sdram_clk_0);
      wb_rst = 1'b0;
      check_cmd("reset_cmd", sdram_ctrl_pkg::NOP, bus_cmd);
      check_bit("reset_ack", 1'b0, wb_ack_o);
      check_bit("reset_dq_oe", 1'b0, dq_oe_o);
      build_table();
      foreach (steps[i]) begin
         bus_access(steps[i], rd_word, waited);
         if (!steps[i].we) begin
            check_data(steps[i].name, steps[i].exp, rd_word);
         end
         if (steps[i].burst) begin
            burst_stalls += waited;
         end
      end
      // six queued writes must overrun the four FIFO entries
      check_count("burst_backpressure", 1, burst_stalls);
      check_count("refresh_count", cycle_cnt / `SDR_REF_PERIOD - 1, ref_count);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/sdram_ctrl_chk.sv
`default_nettype none

module sdram_ctrl_chk (
   input wire                        sdram_clk_0,
   input wire                        wb_rst,
   input sdram_ctrl_pkg::seq_state_e state_i,
   input sdram_ctrl_pkg::sdr_cmd_e   cmd_i,
   input wire                        dq_oe_i,
   input wire                        pop_i,
   input wire                        empty_i
);

   // data bus driven only during the two write beats
   a_dq_oe_in_write : assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      dq_oe_i |-> (state_i == sdram_ctrl_pkg::WR_HI || state_i == sdram_ctrl_pkg::WR_LO))
      else $error("dq_oe high outside the write beats");

   // recovery windows carry NOP only
   a_nop_in_recovery : assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      (state_i == sdram_ctrl_pkg::REF_WAIT || state_i == sdram_ctrl_pkg::PRE_WAIT)
      |-> (cmd_i == sdram_ctrl_pkg::NOP))
      else $error("command other than NOP during precharge or refresh recovery");

   a_no_pop_when_empty : assert property (@(posedge sdram_clk_0) disable iff (wb_rst)
      pop_i |-> !empty_i)
      else $error("pop from an empty command FIFO");

endmodule

bind sdr_cmd_seq sdram_ctrl_chk i_sdram_ctrl_chk (
   .sdram_clk_0 (sdram_clk_0),
   .wb_rst      (wb_rst),
   .state_i     (state),
   .cmd_i       (cmd_o),
   .dq_oe_i     (dq_oe_o),
   .pop_i       (pop_o),
   .empty_i     (empty_i)
);

`default_nettype wire

// File: verilog/wb_sdram_ctrl_top.sv
`default_nettype none

`include "sdram_ctrl_defs.svh"

module wb_sdram_ctrl_top (
   input  wire                    sdram_clk_0,
   input  wire                    wb_rst,
   input  wire [`WB_ADR_W-1:0]    wb_adr_i,
   input  wire [`WB_DAT_W-1:0]    wb_dat_i,
   input  wire [`WB_SEL_W-1:0]    wb_sel_i,
   input  wire                    wb_we_i,
   input  wire                    wb_cyc_i,
   input  wire                    wb_stb_i,
   input  wire [`SDR_DQ_W-1:0]    dq_i,
   output wire [`WB_DAT_W-1:0]    wb_dat_o,
   output wire                    wb_ack_o,
   output wire                    ras_n_o,
   output wire                    cas_n_o,
   output wire                    we_n_o,
   output wire [`SDR_BA_W-1:0]    ba_o,
   output wire [`SDR_A_W-1:0]     a_o,
   output wire [`SDR_DQM_W-1:0]   dqm_o,
   output wire [`SDR_DQ_W-1:0]    dq_o,
   output wire                    dq_oe_o
);

   // address, write flag, selects and data
   localparam int ENTRY_W = `WB_ADR_W + 1 + `WB_SEL_W + `WB_DAT_W;

   wire                 push;
   wire [ENTRY_W-1:0]   entry;
   wire                 fifo_full;
   wire                 pop;
   wire [ENTRY_W-1:0]   head;
   wire                 fifo_empty;
   wire                 rd_valid;
   wire [`WB_DAT_W-1:0] rd_data;
   wire [2:0]           seq_cmd;

   assign {ras_n_o, cas_n_o, we_n_o} = seq_cmd;

   wb_cmd_packer i_wb_cmd_packer (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .fifo_full_i (fifo_full),
      .rd_valid_i  (rd_valid),
      .rd_data_i   (rd_data),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .push_o      (push),
      .entry_o     (entry)
   );

   cmd_fifo i_cmd_fifo (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .push_i      (push),
      .entry_i     (entry),
      .pop_i       (pop),
      .head_o      (head),
      .full_o      (fifo_full),
      .empty_o     (fifo_empty)
   );

   sdr_cmd_seq i_sdr_cmd_seq (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .head_i      (head),
      .empty_i     (fifo_empty),
      .dq_i        (dq_i),
      .pop_o       (pop),
      .cmd_o       (seq_cmd),
      .ba_o        (ba_o),
      .a_o         (a_o),
      .dqm_o       (dqm_o),
      .dq_o        (dq_o),
      .dq_oe_o     (dq_oe_o),
      .rd_valid_o  (rd_valid),
      .rd_data_o   (rd_data)
   );

endmodule

`default_nettype wire

// File: verilog/sdr_cmd_seq.sv
`default_nettype none

`include "sdram_ctrl_defs.svh"

module sdr_cmd_seq (
   input  wire                         sdram_clk_0,
   input  wire                         wb_rst,
   input  sdram_ctrl_pkg::cmd_entry_t  head_i,
   input  wire                         empty_i,
   input  wire [`SDR_DQ_W-1:0]         dq_i,
   output logic                        pop_o,
   output sdram_ctrl_pkg::sdr_cmd_e    cmd_o,
   output logic [`SDR_BA_W-1:0]        ba_o,
   output logic [`SDR_A_W-1:0]         a_o,
   output logic [`SDR_DQM_W-1:0]       dqm_o,
   output logic [`SDR_DQ_W-1:0]        dq_o,
   output logic                        dq_oe_o,
   output logic                        rd_valid_o,
   output sdram_ctrl_pkg::wb_data_t    rd_data_o
);

   localparam int COL_W     = `WB_ADR_W - `SDR_BA_W - `SDR_A_W;
   localparam int REF_CNT_W = $clog2(`SDR_REF_PERIOD);

   sdram_ctrl_pkg::seq_state_e state;
   sdram_ctrl_pkg::cmd_entry_t cur;

   logic [3:0]              wait_cnt;
   logic [REF_CNT_W-1:0]    ref_cnt;
   logic                    ref_tick;
   logic                    ref_req;
   logic                    ref_issue;
   logic                    rd_issue;
   logic [`SDR_CL-1:0]      rd_pipe;
   logic                    lo_stb;
   logic [`SDR_DQ_W-1:0]    hi_q;
   logic [`SDR_A_W-1:0]     col_addr;

   // column word times two, A10 set for auto-precharge
   assign col_addr = {{(`SDR_A_W-COL_W-3){1'b0}}, 1'b1, 1'b0, cur.adr[COL_W-1:0], 1'b0};

   assign ref_tick = (ref_cnt == REF_CNT_W'(`SDR_REF_PERIOD-1));

   always_comb begin
      cmd_o     = sdram_ctrl_pkg::NOP;
      ba_o      = cur.adr[`WB_ADR_W-1 -: `SDR_BA_W];
      a_o       = col_addr;
      dqm_o     = '0;
      dq_o      = '0;
      dq_oe_o   = 1'b0;
      pop_o     = 1'b0;
      ref_issue = 1'b0;
      rd_issue  = 1'b0;
      case (state)
         sdram_ctrl_pkg::IDLE: begin
            // refresh wins over a queued access
            if (ref_req) begin
               cmd_o     = sdram_ctrl_pkg::REFRESH;
               ref_issue = 1'b1;
            end else if (!empty_i) begin
               pop_o = 1'b1;
               cmd_o = sdram_ctrl_pkg::ACTIVATE;
               ba_o  = head_i.adr[`WB_ADR_W-1 -: `SDR_BA_W];
               a_o   = head_i.adr[COL_W +: `SDR_A_W];
            end
         end
         sdram_ctrl_pkg::WR_HI: begin
            cmd_o   = sdram_ctrl_pkg::WRITE;
            dqm_o   = ~cur.sel[3:2];
            dq_o    = cur.dat[31:16];
            dq_oe_o = 1'b1;
         end
         sdram_ctrl_pkg::WR_LO: begin
            dqm_o   = ~cur.sel[1:0];
            dq_o    = cur.dat[15:0];
            dq_oe_o = 1'b1;
         end
         sdram_ctrl_pkg::RD_WAIT: begin
            // first cycle of the wait carries the READ
            if (wait_cnt == 4'(`SDR_CL)) begin
               cmd_o    = sdram_ctrl_pkg::READ;
               rd_issue = 1'b1;
            end
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         state    <= sdram_ctrl_pkg::IDLE;
         wait_cnt <= '0;
      end else begin
         case (state)
            sdram_ctrl_pkg::IDLE: begin
               if (ref_req) begin
                  state    <= sdram_ctrl_pkg::REF_WAIT;
                  wait_cnt <= 4'(`SDR_TRFC-1);
               end else if (!empty_i) begin
                  state    <= sdram_ctrl_pkg::ACT_WAIT;
                  wait_cnt <= 4'(`SDR_TRCD-2);
               end
            end
            sdram_ctrl_pkg::ACT_WAIT: begin
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 4'd1;
               end else if (cur.we) begin
                  state <= sdram_ctrl_pkg::WR_HI;
               end else begin
                  state    <= sdram_ctrl_pkg::RD_WAIT;
                  wait_cnt <= 4'(`SDR_CL);
               end
            end
            sdram_ctrl_pkg::WR_HI: begin
               state <= sdram_ctrl_pkg::WR_LO;
            end
            sdram_ctrl_pkg::RD_WAIT: begin
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 4'd1;
               end else begin
                  state <= sdram_ctrl_pkg::RD_LO;
               end
            end
            sdram_ctrl_pkg::WR_LO, sdram_ctrl_pkg::RD_LO: begin
               state    <= sdram_ctrl_pkg::PRE_WAIT;
               wait_cnt <= 4'(`SDR_TRP-1);
            end
            default: begin
               // precharge and refresh recovery
               if (wait_cnt != '0) begin
                  wait_cnt <= wait_cnt - 4'd1;
               end else begin
                  state <= sdram_ctrl_pkg::IDLE;
               end
            end
         endcase
      end
   end

   // refresh timer, a new tick beats a clear in the same cycle
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         ref_cnt <= '0;
         ref_req <= 1'b0;
      end else begin
         ref_cnt <= ref_tick ? '0 : ref_cnt + 1'b1;
         if (ref_tick) begin
            ref_req <= 1'b1;
         end else if (ref_issue) begin
            ref_req <= 1'b0;
         end
      end
   end

   // read strobes, high beat at the edge ending cycle READ+CL
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         rd_pipe    <= '0;
         lo_stb     <= 1'b0;
         rd_valid_o <= 1'b0;
      end else begin
         rd_pipe    <= {rd_pipe[`SDR_CL-2:0], rd_issue};
         lo_stb     <= rd_pipe[`SDR_CL-1];
         rd_valid_o <= lo_stb;
      end
   end

   always_ff @(posedge sdram_clk_0) begin
      if (pop_o) begin
         cur <= head_i;
      end
      if (rd_pipe[`SDR_CL-1]) begin
         hi_q <= dq_i;
      end
      if (lo_stb) begin
         rd_data_o <= {hi_q, dq_i};
      end
   end

endmodule

`default_nettype wire

// File: verilog/cmd_fifo.sv
`default_nettype none

`include "sdram_ctrl_defs.svh"

module cmd_fifo (
   input  wire                         sdram_clk_0,
   input  wire                         wb_rst,
   input  wire                         push_i,
   input  sdram_ctrl_pkg::cmd_entry_t  entry_i,
   input  wire                         pop_i,
   output sdram_ctrl_pkg::cmd_entry_t  head_o,
   output logic                        full_o,
   output logic                        empty_o
);

   sdram_ctrl_pkg::cmd_entry_t mem [`FIFO_DEPTH];

   logic [`FIFO_PTR_W-1:0] wr_ptr;
   logic [`FIFO_PTR_W-1:0] rd_ptr;
   logic [`FIFO_PTR_W:0]   count;

   // show-ahead, head is valid whenever not empty
   assign head_o  = mem[rd_ptr];
   assign full_o  = (count == (`FIFO_PTR_W+1)'(`FIFO_DEPTH));
   assign empty_o = (count == '0);

   always_ff @(posedge sdram_clk_0) begin
      if (push_i) begin
         mem[wr_ptr] <= entry_i;
      end
   end

   // pointers wrap at the power-of-two depth
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/wb_cmd_packer.sv
`default_nettype none

module wb_cmd_packer (
   input  wire                         sdram_clk_0,
   input  wire                         wb_rst,
   input  sdram_ctrl_pkg::wb_adr_t     wb_adr_i,
   input  sdram_ctrl_pkg::wb_data_t    wb_dat_i,
   input  sdram_ctrl_pkg::wb_sel_t     wb_sel_i,
   input  wire                         wb_we_i,
   input  wire                         wb_cyc_i,
   input  wire                         wb_stb_i,
   input  wire                         fifo_full_i,
   input  wire                         rd_valid_i,
   input  sdram_ctrl_pkg::wb_data_t    rd_data_i,
   output sdram_ctrl_pkg::wb_data_t    wb_dat_o,
   output logic                        wb_ack_o,
   output logic                        push_o,
   output sdram_ctrl_pkg::cmd_entry_t  entry_o
);

   logic                     rd_pend;
   logic                     rd_ack_q;
   sdram_ctrl_pkg::wb_data_t rd_dat_q;

   // master holds everything until ack, so the bus is the entry
   always_comb begin
      entry_o.adr = wb_adr_i;
      entry_o.we  = wb_we_i;
      entry_o.sel = wb_sel_i;
      entry_o.dat = wb_dat_i;
   end

   // only one read may be in flight
   assign push_o = wb_cyc_i & wb_stb_i & ~rd_pend & ~fifo_full_i;

   // posted write acks on push, read acks when data is back
   assign wb_ack_o = (push_o & wb_we_i) | rd_ack_q;
   assign wb_dat_o = rd_dat_q;

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         rd_pend  <= 1'b0;
         rd_ack_q <= 1'b0;
      end else begin
         rd_ack_q <= rd_valid_i;
         if (push_o && !wb_we_i) begin
            rd_pend <= 1'b1;
         end else if (rd_ack_q) begin
            rd_pend <= 1'b0;
         end
      end
   end

   // returned word, held for the ack cycle
   always_ff @(posedge sdram_clk_0) begin
      if (rd_valid_i) begin
         rd_dat_q <= rd_data_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/sdram_ctrl_pkg.sv
`default_nettype none

`include "sdram_ctrl_defs.svh"

package sdram_ctrl_pkg;

   typedef logic [`WB_DAT_W-1:0] wb_data_t;
   typedef logic [`WB_ADR_W-1:0] wb_adr_t;
   typedef logic [`WB_SEL_W-1:0] wb_sel_t;

   // one queued wishbone access
   typedef struct packed {
      wb_adr_t  adr;
      logic     we;
      wb_sel_t  sel;
      wb_data_t dat;
   } cmd_entry_t;

   // encoded as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      NOP       = 3'b111,
      ACTIVATE  = 3'b011,
      READ      = 3'b101,
      WRITE     = 3'b100,
      PRECHARGE = 3'b010,
      REFRESH   = 3'b001
   } sdr_cmd_e;

   typedef enum logic [2:0] {
      IDLE, ACT_WAIT, WR_HI, WR_LO, RD_WAIT, RD_LO, PRE_WAIT, REF_WAIT
   } seq_state_e;

endpackage

`default_nettype wire

// File: verilog/sdram_ctrl_defs.svh
`ifndef SDRAM_CTRL_DEFS_SVH
`define SDRAM_CTRL_DEFS_SVH

// wishbone side
`define WB_DAT_W 32
`define WB_SEL_W 4
// word address is bank, row, column word
`define WB_ADR_W 23

// sdram pins
`define SDR_DQ_W  16
`define SDR_DQM_W 2
`define SDR_BA_W  2
`define SDR_A_W   13

// sdram timing in clock cycles
`define SDR_CL         2
`define SDR_TRCD       2
`define SDR_TRP        2
`define SDR_TRFC       7
`define SDR_REF_PERIOD 100

// command fifo
`define FIFO_DEPTH 4
`define FIFO_PTR_W 2

`endif
